// ==== src/gpio_params.svh ====
// widths and reset values of the gpio block
// div and hold widths must stay at or below 16 bits, one bus word
`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

// board pins
`define GPIO_LED_W    14   // led bank, fits one 16-bit word
`define GPIO_SW_W     8    // slide switches

// prescaler and debouncer
`define GPIO_DIV_W    16   // tick divisor width
`define GPIO_HOLD_W   3    // lockout count width

// configuration after reset
`define GPIO_DIV_RST  49999  // 1 ms tick at 50 MHz
`define GPIO_HOLD_RST 7      // lockout in ticks

`endif

// ==== src/wb_pkg.sv ====
// classic wishbone slave types, 16-bit data, word addressed
// no stall, err or retry signals
package wb_pkg;

  typedef struct packed {
    logic [18:0] adr;  // word address, bus bits 19:1
    logic [15:0] dat;  // write data
    logic [1:0]  sel;  // byte lanes
    logic        we;
    logic        stb;
    logic        cyc;
  } wb_req_t;

  typedef struct packed {
    logic [15:0] dat;  // read data, valid with ack
    logic        ack;
  } wb_rsp_t;

  // overlay enabled byte lanes of dat onto old
  function automatic logic [15:0] byte_merge(input logic [15:0] old,
                                             input logic [15:0] dat,
                                             input logic [1:0]  sel);
    logic [15:0] res;
    res = old;
    for (int i = 0; i < 2; i++)
    begin
      if (sel[i]) res[i*8 +: 8] = dat[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

// ==== src/gpio_pkg.sv ====
// gpio block types, register map indexed by address bits 2:1
`include "gpio_params.svh"

package gpio_pkg;

  // register index, bus address bits 2:1
  typedef enum logic [1:0] {
    REG_SW   = 2'd0,  // switches, read only
    REG_LED  = 2'd1,  // led bank
    REG_DIV  = 2'd2,  // tick divisor
    REG_HOLD = 2'd3   // lockout length in ticks
  } gpio_reg_e;

  // live configuration
  typedef struct packed {
    logic [`GPIO_DIV_W-1:0]  tick_div;  // tick period minus one
    logic [`GPIO_HOLD_W-1:0] hold;      // ticks to ignore the button
  } gpio_cfg_t;

endpackage

// ==== src/gpio_wb_decode.sv ====
// splits the slave space in two halves by address bit 2
// purely combinational, adds no wait states
`timescale 1ns/1ns

module gpio_wb_decode (
  input  wb_pkg::wb_req_t wb_i,       // from the master
  output wb_pkg::wb_rsp_t wb_o,       // to the master
  output wb_pkg::wb_req_t io_req_o,   // led/switch half
  output wb_pkg::wb_req_t cfg_req_o,  // config half
  input  wb_pkg::wb_rsp_t io_rsp_i,
  input  wb_pkg::wb_rsp_t cfg_rsp_i
);

  logic sel_cfg;  // high for REG_DIV and REG_HOLD

  assign sel_cfg = wb_i.adr[1];  // bus address bit 2

  // request fan-out, only one half sees the strobe
  always_comb
  begin
    io_req_o      = wb_i;
    cfg_req_o     = wb_i;
    io_req_o.stb  = wb_i.stb & ~sel_cfg;
    cfg_req_o.stb = wb_i.stb &  sel_cfg;
  end

  // response mux
  always_comb
  begin
    if (sel_cfg)
    begin
      wb_o = cfg_rsp_i;
    end
    else
    begin
      wb_o = io_rsp_i;
    end
  end

endmodule

// ==== src/gpio_cfg_regs.sv ====
// tick divisor and lockout registers, byte-lane writes
// sees only the upper half of the map, so address bit 2 is implied 1
`timescale 1ns/1ns
`include "gpio_params.svh"

module gpio_cfg_regs (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  wb_pkg::wb_req_t   req_i,
  output wb_pkg::wb_rsp_t   rsp_o,
  output gpio_pkg::gpio_cfg_t cfg_o,
  output logic              div_wr_o   // restart pulse for the prescaler
);

  logic                  op;        // valid transfer
  logic                  wr;        // valid write
  gpio_pkg::gpio_reg_e   reg_idx;   // REG_DIV or REG_HOLD
  logic [15:0]           div_next;  // divisor after byte merge
  logic [15:0]           hold_next; // hold after byte merge

  assign op      = req_i.cyc & req_i.stb;
  assign wr      = op & req_i.we;
  assign reg_idx = gpio_pkg::gpio_reg_e'({1'b1, req_i.adr[0]});

  assign div_wr_o = wr & (reg_idx == gpio_pkg::REG_DIV);

  // merged words, upper bits dropped on store
  assign div_next  = wb_pkg::byte_merge(16'(cfg_o.tick_div), req_i.dat, req_i.sel);
  assign hold_next = wb_pkg::byte_merge(16'(cfg_o.hold), req_i.dat, req_i.sel);

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      cfg_o.tick_div <= `GPIO_DIV_W'(`GPIO_DIV_RST);
      cfg_o.hold     <= `GPIO_HOLD_W'(`GPIO_HOLD_RST);
    end
    else if (wr)
    begin
      if (reg_idx == gpio_pkg::REG_DIV)
      begin
        cfg_o.tick_div <= div_next[`GPIO_DIV_W-1:0];
      end
      else
      begin
        cfg_o.hold <= hold_next[`GPIO_HOLD_W-1:0];
      end
    end
  end

  // zero wait state response, readback zero-extended
  always_comb
  begin
    rsp_o.ack = op;
    if (reg_idx == gpio_pkg::REG_DIV)
    begin
      rsp_o.dat = 16'(cfg_o.tick_div);
    end
    else
    begin
      rsp_o.dat = 16'(cfg_o.hold);
    end
  end

endmodule

// ==== src/tick_gen.sv ====
// free-running prescaler, one-cycle tick every div_i + 1 clocks
// lowering div_i below the running count wraps at the next edge
`timescale 1ns/1ns
`include "gpio_params.svh"

module tick_gen (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic [`GPIO_DIV_W-1:0] div_i,      // period minus one
  input  logic                   restart_i,  // divisor written
  output logic                   tick_o
);

  logic [`GPIO_DIV_W-1:0] cnt;  // 0 .. div_i
  logic                   wrap;

  assign wrap = (cnt >= div_i);

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i || restart_i)
    begin
      cnt    <= '0;
      tick_o <= 1'b0;
    end
    else
    begin
      tick_o <= wrap;  // registered, high for one clock
      if (wrap)
      begin
        cnt <= '0;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/sw_leds.sv ====
// led bank, switch readback and push-button nmi with tick lockout
// sees only the lower half of the map, the switches are not debounced
`timescale 1ns/1ns
`include "gpio_params.svh"

module sw_leds (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  wb_pkg::wb_req_t         req_i,
  output wb_pkg::wb_rsp_t         rsp_o,
  input  logic [`GPIO_SW_W-1:0]   sw_i,
  input  logic                    pb_n_i,   // active low button
  input  logic                    tick_i,   // debounce tick
  input  logic [`GPIO_HOLD_W-1:0] hold_i,   // lockout in ticks
  output logic [`GPIO_LED_W-1:0]  led_o,
  output logic                    nmi_o
);

  logic                    op;
  logic                    wr_led;
  gpio_pkg::gpio_reg_e     reg_idx;   // REG_SW or REG_LED
  logic [15:0]             led_next;
  logic                    pressed;   // registered button level
  logic [`GPIO_HOLD_W-1:0] lock_cnt;  // ticks seen since last change
  logic                    ready;

  assign op      = req_i.cyc & req_i.stb;
  assign reg_idx = gpio_pkg::gpio_reg_e'({1'b0, req_i.adr[0]});
  assign wr_led  = op & req_i.we & (reg_idx == gpio_pkg::REG_LED);

  // read mux, zero-extended, valid with ack
  always_comb
  begin
    rsp_o.ack = op;
    if (reg_idx == gpio_pkg::REG_LED)
    begin
      rsp_o.dat = 16'(led_o);
    end
    else
    begin
      rsp_o.dat = 16'(sw_i);  // writes here are dropped
    end
  end

  assign led_next = wb_pkg::byte_merge(16'(led_o), req_i.dat, req_i.sel);

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      led_o <= '0;
    end
    else if (wr_led)
    begin
      led_o <= led_next[`GPIO_LED_W-1:0];  // bits above the bank dropped
    end
  end

  // lockout over once hold_i ticks seen, hold_i of 0 means no lockout
  assign ready = (lock_cnt >= hold_i);

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      pressed  <= 1'b0;
      nmi_o    <= 1'b0;
      lock_cnt <= '1;  // starts ready for any hold
    end
    else
    begin
      pressed <= ~pb_n_i;  // single sync stage
      if (ready)
      begin
        if (pressed != nmi_o)
        begin
          nmi_o    <= pressed;  // follow the new level
          lock_cnt <= '0;       // then ignore the pin
        end
      end
      else if (tick_i)
      begin
        lock_cnt <= lock_cnt + 1'b1;  // stops at hold_i
      end
    end
  end

endmodule

// ==== src/gpio_top.sv ====
// gpio subsystem, wishbone slave with zero wait states
// nmi_o is a level, the interrupt acknowledge lives elsewhere
`timescale 1ns/1ns
`include "gpio_params.svh"

module gpio_top (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic [19:1]            wb_adr_i,
  input  logic [15:0]            wb_dat_i,
  output logic [15:0]            wb_dat_o,
  input  logic [1:0]             wb_sel_i,
  input  logic                   wb_we_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_cyc_i,
  output logic                   wb_ack_o,
  input  logic [`GPIO_SW_W-1:0]  sw_i,
  input  logic                   pb_n_i,
  output logic [`GPIO_LED_W-1:0] led_o,
  output logic                   nmi_o
);

  wb_pkg::wb_req_t     bus_req, io_req, cfg_req;
  wb_pkg::wb_rsp_t     bus_rsp, io_rsp, cfg_rsp;
  gpio_pkg::gpio_cfg_t cfg;
  logic                div_wr;  // divisor written, restart prescaler
  logic                tick;

  assign bus_req  = '{adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i,
                      we: wb_we_i, stb: wb_stb_i, cyc: wb_cyc_i};
  assign wb_dat_o = bus_rsp.dat;
  assign wb_ack_o = bus_rsp.ack;

  gpio_wb_decode i_decode (.wb_i(bus_req), .wb_o(bus_rsp), .io_req_o(io_req),
    .cfg_req_o(cfg_req), .io_rsp_i(io_rsp), .cfg_rsp_i(cfg_rsp));

  gpio_cfg_regs i_cfg_regs (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .req_i(cfg_req),
    .rsp_o(cfg_rsp), .cfg_o(cfg), .div_wr_o(div_wr));

  tick_gen i_tick_gen (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .div_i(cfg.tick_div),
    .restart_i(div_wr), .tick_o(tick));

  sw_leds i_sw_leds (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .req_i(io_req),
    .rsp_o(io_rsp), .sw_i(sw_i), .pb_n_i(pb_n_i), .tick_i(tick), .hold_i(cfg.hold),
    .led_o(led_o), .nmi_o(nmi_o));

endmodule

// ==== testbench/gpio_tb_tasks.svh ====
// bus access, compare and stop tasks, included inside gpio_tb
// uses the bus and board signals declared in the testbench module
task automatic stop_run();
  $display("RESULT: FAIL");
  $fatal(1, "simulation stopped at the first error");
endtask

// wrong value, signal name and hex values
task automatic flag_mismatch(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
  $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
  stop_run();
endtask

// timeouts and other plain failures
task automatic abort_run(input string why);
  $display("%s", why);
  stop_run();
endtask

// data only compared when asked, writes return nothing defined
task automatic check_rsp(input wb_pkg::wb_rsp_t got, input wb_pkg::wb_rsp_t exp,
                         input logic chk_dat);
  if (got.ack !== exp.ack) flag_mismatch("wb_ack_o", 16'(got.ack), 16'(exp.ack));
  if (chk_dat && (got.dat !== exp.dat)) flag_mismatch("wb_dat_o", got.dat, exp.dat);
endtask

task automatic check_led(input logic [`GPIO_LED_W-1:0] got,
                         input logic [`GPIO_LED_W-1:0] exp);
  if (got !== exp) flag_mismatch("led_o", 16'(got), 16'(exp));
endtask

task automatic check_nmi(input logic got, input logic exp);
  if (got !== exp) flag_mismatch("nmi_o", 16'(got), 16'(exp));
endtask

// one transfer, cyc gates the strobe, ack expected in the same cycle
task automatic bus_access(input gpio_pkg::gpio_reg_e idx, input logic we,
                          input logic [15:0] dat, input logic [1:0] sel,
                          input logic cyc, input logic [15:0] exp);
  wb_pkg::wb_rsp_t got;
  wb_pkg::wb_rsp_t want;
  @(negedge wb_clk_i);
  wb_adr_i = {17'h0, idx};  // index on address bits 2:1
  wb_dat_i = dat;
  wb_sel_i = sel;
  wb_we_i  = we;
  wb_stb_i = 1'b1;
  wb_cyc_i = cyc;
  #1;  // combinational ack settled
  got  = '{dat: wb_dat_o, ack: wb_ack_o};
  want = '{dat: exp, ack: cyc};
  check_rsp(got, want, cyc & ~we);
  @(posedge wb_clk_i);  // write commits here
  @(negedge wb_clk_i);
  wb_stb_i = 1'b0;
  wb_cyc_i = 1'b0;
  wb_we_i  = 1'b0;
endtask

// ==== testbench/gpio_tb.sv ====
// table-driven self-checking testbench for gpio_top
// inputs change on the falling edge and the run stops at the first error
`timescale 1ns/1ns
`include "gpio_params.svh"

module gpio_tb;

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_PRESS} op_e;

  typedef struct packed {
    op_e                 op;
    gpio_pkg::gpio_reg_e idx;
    logic [15:0]         dat;
    logic [1:0]          sel;
    logic [15:0]         exp;  // readback or led_o after an led write
  } step_t;

  localparam int N_STEPS    = 24;
  localparam int CFG_DIV    = 3;  // tick period 4 clocks
  localparam int CFG_HOLD   = 4;  // lockout in ticks
  localparam int RISE_LIMIT = 8;
  localparam int MIN_HIGH   = (CFG_HOLD - 1) * (CFG_DIV + 1);
  localparam int FALL_LIMIT = CFG_HOLD * (CFG_DIV + 1) + 4;

  logic                   wb_clk_i;
  logic                   wb_rst_i;
  logic [19:1]            wb_adr_i;
  logic [15:0]            wb_dat_i;
  logic [15:0]            wb_dat_o;
  logic [1:0]             wb_sel_i;
  logic                   wb_we_i;
  logic                   wb_stb_i;
  logic                   wb_cyc_i;
  logic                   wb_ack_o;
  logic [`GPIO_SW_W-1:0]  sw_i;
  logic                   pb_n_i;
  logic [`GPIO_LED_W-1:0] led_o;
  logic                   nmi_o;

  step_t steps [N_STEPS];
  int    seed;
  int    rnd;
  logic [15:0] sw_word;    // switch value as a bus word, upper bits zero
  logic [15:0] led_model;  // last led value written

  gpio_top i_gpio_top (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i),
    .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i), .wb_ack_o(wb_ack_o), .sw_i(sw_i),
    .pb_n_i(pb_n_i), .led_o(led_o), .nmi_o(nmi_o));

  `include "gpio_tb_tasks.svh"

  initial
  begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;  // 10 ns period
  end

  // expected values follow the register map and byte lane rules
  task automatic load_steps();
    steps[0]  = '{OP_RD, gpio_pkg::REG_LED,  16'h0000, 2'b11, 16'h0000};
    steps[1]  = '{OP_RD, gpio_pkg::REG_DIV,  16'h0000, 2'b11, 16'(`GPIO_DIV_RST)};
    steps[2]  = '{OP_RD, gpio_pkg::REG_HOLD, 16'h0000, 2'b11, 16'(`GPIO_HOLD_RST)};
    steps[3]  = '{OP_RD, gpio_pkg::REG_SW,   16'h0000, 2'b11, sw_word};
    steps[4]  = '{OP_WR, gpio_pkg::REG_SW,   16'hffff, 2'b11, 16'h0000};  // read only
    steps[5]  = '{OP_RD, gpio_pkg::REG_SW,   16'h0000, 2'b11, sw_word};
    steps[6]  = '{OP_RD, gpio_pkg::REG_LED,  16'h0000, 2'b11, 16'h0000};
    steps[7]  = '{OP_WR, gpio_pkg::REG_LED,  16'hffff, 2'b01, 16'h00ff};  // low byte
    steps[8]  = '{OP_RD, gpio_pkg::REG_LED,  16'h0000, 2'b11, 16'h00ff};
    steps[9]  = '{OP_WR, gpio_pkg::REG_LED,  16'hffff, 2'b10, 16'h3fff};  // 14 bits only
    steps[10] = '{OP_RD, gpio_pkg::REG_LED,  16'h0000, 2'b11, 16'h3fff};
    steps[11] = '{OP_WR, gpio_pkg::REG_LED,  16'h1234, 2'b01, 16'h3f34};
    steps[12] = '{OP_RD, gpio_pkg::REG_LED,  16'h0000, 2'b11, 16'h3f34};
    steps[13] = '{OP_WR, gpio_pkg::REG_LED,  16'ha5c3, 2'b11, 16'h25c3};
    steps[14] = '{OP_RD, gpio_pkg::REG_LED,  16'h0000, 2'b11, 16'h25c3};
    steps[15] = '{OP_WR, gpio_pkg::REG_DIV,  16'habcd, 2'b10, 16'hab4f};  // 0xc34f old
    steps[16] = '{OP_RD, gpio_pkg::REG_DIV,  16'h0000, 2'b11, 16'hab4f};
    steps[17] = '{OP_WR, gpio_pkg::REG_DIV,  16'(CFG_DIV), 2'b11, 16'(CFG_DIV)};
    steps[18] = '{OP_RD, gpio_pkg::REG_DIV,  16'h0000, 2'b11, 16'(CFG_DIV)};
    steps[19] = '{OP_WR, gpio_pkg::REG_HOLD, 16'hfffc, 2'b10, 16'(`GPIO_HOLD_RST)};
    steps[20] = '{OP_RD, gpio_pkg::REG_HOLD, 16'h0000, 2'b11, 16'(`GPIO_HOLD_RST)};
    steps[21] = '{OP_WR, gpio_pkg::REG_HOLD, 16'h00f8 | 16'(CFG_HOLD), 2'b01, 16'(CFG_HOLD)};
    steps[22] = '{OP_RD, gpio_pkg::REG_HOLD, 16'h0000, 2'b11, 16'(CFG_HOLD)};
    steps[23] = '{OP_PRESS, gpio_pkg::REG_SW, 16'h0000, 2'b00, 16'h0000};
  endtask

  // press and release at once then time the lockout
  task automatic press_check();
    logic rose;
    logic fell;
    @(negedge wb_clk_i);
    pb_n_i = 1'b0;
    rose   = 1'b0;
    for (int c = 1; c <= RISE_LIMIT && !rose; c++)
    begin
      @(negedge wb_clk_i);
      rose = nmi_o;
    end
    if (!rose) abort_run("timeout, nmi_o did not rise after the button press");
    pb_n_i = 1'b1;  // released right away
    fell   = 1'b0;
    for (int c = 1; c <= FALL_LIMIT && !fell; c++)
    begin
      @(negedge wb_clk_i);
      if (c <= MIN_HIGH) check_nmi(nmi_o, 1'b1);  // still locked out
      else fell = ~nmi_o;
    end
    if (!fell) abort_run("timeout, nmi_o did not fall after the lockout");
  endtask

  initial
  begin
    wb_rst_i  = 1'b1;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    wb_we_i   = 1'b0;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    sw_i      = '0;
    pb_n_i    = 1'b1;  // button up
    seed      = 55;
    led_model = '0;
    repeat (3) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    rnd  = $random(seed);
    sw_i = rnd[`GPIO_SW_W-1:0];
    sw_word = '0;
    sw_word[`GPIO_SW_W-1:0] = rnd[`GPIO_SW_W-1:0];
    check_led(led_o, '0);
    check_nmi(nmi_o, 1'b0);
    load_steps();
    for (int i = 0; i < N_STEPS; i++)
    begin
      case (steps[i].op)
        OP_RD: bus_access(steps[i].idx, 1'b0, 16'h0, steps[i].sel, 1'b1, steps[i].exp);
        OP_WR:
        begin
          bus_access(steps[i].idx, 1'b1, steps[i].dat, steps[i].sel, 1'b1, 16'h0);
          if (steps[i].idx == gpio_pkg::REG_LED)
          begin
            led_model = steps[i].exp;
          end
          check_led(led_o, led_model[`GPIO_LED_W-1:0]);  // one edge after ack
        end
        default:
        begin
          // a strobe without cyc must give no ack and leave the leds alone
          bus_access(gpio_pkg::REG_LED, 1'b1, 16'h0000, 2'b11, 1'b0, 16'h0);
          check_led(led_o, led_model[`GPIO_LED_W-1:0]);
          press_check();
        end
      endcase
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
+incdir+testbench
src/wb_pkg.sv
src/gpio_pkg.sv
src/gpio_wb_decode.sv
src/gpio_cfg_regs.sv
src/tick_gen.sv
src/sw_leds.sv
src/gpio_top.sv
testbench/gpio_tb.sv

// ==== Makefile ====
# Verilator flow for the gpio block, all variables can be set on the command line
VERILATOR ?= verilator
FLIST     ?= list.f
TOP       ?= gpio_tb
RTL_TOP   ?= gpio_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_STR  ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(wildcard src/*.sv src/*.svh testbench/*.sv testbench/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
